// ==== hdl/alloc_scatter.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

// spreads consecutive dequeued entries onto the requesting lanes
// inverse of the dealloc compaction: deq x,x,b,a with req 1001 -> b,x,x,a
module alloc_scatter (
    input  logic [`RENAME_WIDTH-1:0] i_req_vld,
    input  rename_pkg::alloc_vec_t   i_deq_data,
    output rename_pkg::alloc_vec_t   o_pr_idx
);

    localparam int LANE_IDX_W = $clog2(`RENAME_WIDTH);

    // requesting lanes strictly below each lane pick the dequeue position
    rename_pkg::lane_cnt_t below [`RENAME_WIDTH];

    for (genvar g = 0; g < `RENAME_WIDTH; g++) begin : g_prefix
        assign below[g] = rename_pkg::count_ones(i_req_vld & `RENAME_WIDTH'((1 << g) - 1));
    end

    // idle lanes read back zero, p0 is never a valid allocation
    always_comb begin
        o_pr_idx = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (i_req_vld[i]) begin
                o_pr_idx[i] = i_deq_data[below[i][LANE_IDX_W-1:0]];
            end
        end
    end

endmodule

// ==== hdl/dealloc_compact.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

// packs the valid retire lanes into the low lanes, order kept
// e.g. valid 1010 with indices d,c,b,a  ->  lanes x,x,d,b
module dealloc_compact (
    input  logic [`COMMIT_WIDTH-1:0] i_req_vld,
    input  rename_pkg::dealloc_vec_t i_pr_idx,
    output rename_pkg::dealloc_vec_t o_pr_idx,
    output rename_pkg::lane_cnt_t    o_cnt
);

    localparam int LANE_IDX_W = $clog2(`COMMIT_WIDTH);

    // number of valid lanes strictly below each lane
    rename_pkg::lane_cnt_t below [`COMMIT_WIDTH];

    for (genvar g = 0; g < `COMMIT_WIDTH; g++) begin : g_prefix
        assign below[g] = rename_pkg::count_ones(i_req_vld & `COMMIT_WIDTH'((1 << g) - 1));
    end

    // each valid lane lands on its prefix count
    // below[i] < COMMIT_WIDTH whenever lane i is valid, so the narrow slice is exact
    always_comb begin
        o_pr_idx = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (i_req_vld[i]) begin
                o_pr_idx[below[i][LANE_IDX_W-1:0]] = i_pr_idx[i];
            end
        end
    end

    assign o_cnt = rename_pkg::count_ones(i_req_vld);

endmodule

// ==== hdl/freelist.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

// physical register free list for the rename stage
// allocation is combinational, pointer updates land on the next edge
module freelist (
    input  logic                     clk,
    input  logic                     i_rst_n,

    // rename request, any lane subset
    input  logic [`RENAME_WIDTH-1:0] i_alloc_req,
    output logic                     o_can_alloc,
    output rename_pkg::alloc_vec_t   o_alloc_pr_idx,

    // retired registers coming back, any lane subset
    input  logic [`COMMIT_WIDTH-1:0] i_dealloc_req,
    input  rename_pkg::dealloc_vec_t i_dealloc_pr_idx,

    // from commit
    input  logic [`COMMIT_WIDTH-1:0] i_commit_vld,
    input  logic                     i_resteer_vld
);

    rename_pkg::dealloc_vec_t compact_pr_idx;
    rename_pkg::lane_cnt_t    compact_cnt;

    freelist_if fl_bus ();

    dealloc_compact u_compact (
        .i_req_vld ( i_dealloc_req    ),
        .i_pr_idx  ( i_dealloc_pr_idx ),
        .o_pr_idx  ( compact_pr_idx   ),
        .o_cnt     ( compact_cnt      )
    );

    freelist_ctrl u_ctrl (
        .i_alloc_req   ( i_alloc_req    ),
        .i_resteer_vld ( i_resteer_vld  ),
        .i_commit_vld  ( i_commit_vld   ),
        .i_enq_cnt     ( compact_cnt    ),
        .i_enq_data    ( compact_pr_idx ),
        .o_can_alloc   ( o_can_alloc    ),
        .fl            ( fl_bus.ctrl    )
    );

    freelist_queue u_queue (
        .clk     ( clk          ),
        .i_rst_n ( i_rst_n      ),
        .fl      ( fl_bus.queue )
    );

    alloc_scatter u_scatter (
        .i_req_vld  ( i_alloc_req     ),
        .i_deq_data ( fl_bus.deq_data ),
        .o_pr_idx   ( o_alloc_pr_idx  )
    );

    // rename holds its request mask until granted; a flush may drop it
    a_req_held: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        ((|i_alloc_req) && !o_can_alloc && !i_resteer_vld) |=> $stable(i_alloc_req)
    ) else $error("alloc mask changed while back-pressured");

endmodule

// ==== hdl/freelist_ctrl.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

// grant logic for the free list
// turns the rename lane mask into a dequeue count and forwards retire traffic
module freelist_ctrl (
    input  logic [`RENAME_WIDTH-1:0] i_alloc_req,
    input  logic                     i_resteer_vld,
    input  logic [`COMMIT_WIDTH-1:0] i_commit_vld,
    input  rename_pkg::lane_cnt_t    i_enq_cnt,
    input  rename_pkg::dealloc_vec_t i_enq_data,
    output logic                     o_can_alloc,
    freelist_if.ctrl                 fl
);

    rename_pkg::lane_cnt_t alloc_num;

    assign alloc_num = rename_pkg::count_ones(i_alloc_req);

    // all or nothing: grant only when every requesting lane can be served
    // blocked during a flush so nothing new goes out under a rewind
    assign o_can_alloc = !i_resteer_vld
                         && (fl.free_cnt >= rename_pkg::free_cnt_t'(alloc_num));

    // an empty mask has alloc_num 0, so nothing is popped
    assign fl.deq_cnt = o_can_alloc ? alloc_num : '0;

    // compacted retire lanes go straight in, dealloc is never flushed
    assign fl.enq_cnt  = i_enq_cnt;
    assign fl.enq_data = i_enq_data;

    // commit lanes are in order, only the count matters
    assign fl.commit_cnt = rename_pkg::count_ones(i_commit_vld);
    assign fl.resteer    = i_resteer_vld;

endmodule

// ==== hdl/freelist_if.sv ====
`timescale 1ns/1ns

interface freelist_if;

    // dequeue side
    // entries popped from the speculative head this cycle
    rename_pkg::lane_cnt_t    deq_cnt;
    // next RENAME_WIDTH entries starting at the speculative head, oldest in lane 0
    rename_pkg::alloc_vec_t   deq_data;
    // entries between speculative head and tail
    rename_pkg::free_cnt_t    free_cnt;

    // enqueue side, already compacted into the low lanes
    rename_pkg::lane_cnt_t    enq_cnt;
    rename_pkg::dealloc_vec_t enq_data;

    // commit confirms this many of the oldest speculative allocations
    rename_pkg::lane_cnt_t    commit_cnt;
    // rewind speculative head to the committed head
    logic                     resteer;

    modport ctrl (
        output deq_cnt,
        output enq_cnt,
        output enq_data,
        output commit_cnt,
        output resteer,
        input  free_cnt
    );

    modport queue (
        input  deq_cnt,
        input  enq_cnt,
        input  enq_data,
        input  commit_cnt,
        input  resteer,
        output deq_data,
        output free_cnt
    );

endinterface

// ==== hdl/freelist_queue.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

// circular buffer of free physical registers
//   cmt_head .. spec_head : handed out but not yet confirmed
//   spec_head .. tail     : free, allocatable
module freelist_queue (
    input  logic      clk,
    input  logic      i_rst_n,
    freelist_if.queue fl
);

    localparam int DEPTH  = 1 << `FL_PTR_W;
    localparam int PTR_XW = `FL_PTR_W + 1;

    rename_pkg::pr_idx_t mem [DEPTH];

    logic [`FL_PTR_W-1:0] tail;
    logic [`FL_PTR_W-1:0] spec_head;
    logic [`FL_PTR_W-1:0] cmt_head;
    logic [`FL_PTR_W-1:0] cmt_head_nxt;

    // occupancy checks, one bit wider so an overflow is visible
    logic [PTR_XW-1:0] occ_nxt;
    logic [PTR_XW-1:0] spec_outstanding_nxt;

    assign cmt_head_nxt = cmt_head + `FL_PTR_W'(fl.commit_cnt);

    // storage
    // slot i starts as register i+1, slot 63 wraps to 0 and sits outside the list
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= rename_pkg::pr_idx_t'(i + 1);
            end
        end else begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (i < int'(fl.enq_cnt)) begin
                    mem[tail + `FL_PTR_W'(i)] <= fl.enq_data[i];
                end
            end
        end
    end

    // pointers
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tail      <= `FL_PTR_W'(`IPHYREG_NUM - 1);
            spec_head <= '0;
            cmt_head  <= '0;
        end else begin
            tail     <= tail + `FL_PTR_W'(fl.enq_cnt);
            cmt_head <= cmt_head_nxt;
            // resteer rewinds onto the head after this cycle's commit
            if (fl.resteer) begin
                spec_head <= cmt_head_nxt;
            end else begin
                spec_head <= spec_head + `FL_PTR_W'(fl.deq_cnt);
            end
        end
    end

    // oldest free entries first, lane 0 gets the head
    for (genvar g = 0; g < `RENAME_WIDTH; g++) begin : g_deq
        assign fl.deq_data[g] = mem[spec_head + `FL_PTR_W'(g)];
    end

    assign fl.free_cnt = tail - spec_head;

    // entries still held after this edge, uncommitted ones included
    assign occ_nxt = {1'b0, tail - cmt_head} + PTR_XW'(fl.enq_cnt) - PTR_XW'(fl.commit_cnt);

    // allocations available for commit, this cycle's grant included
    assign spec_outstanding_nxt = {1'b0, spec_head - cmt_head} + PTR_XW'(fl.deq_cnt);

    // dealloc must never overwrite a slot that a resteer could still hand out
    a_enq_room: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        occ_nxt <= PTR_XW'(`IPHYREG_NUM - 1)
    ) else $error("free list overflow: dealloc without room");

    // commit only confirms registers that were actually allocated
    a_commit_le_spec: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        PTR_XW'(fl.commit_cnt) <= spec_outstanding_nxt
    ) else $error("commit passes the speculative head");

endmodule

// ==== hdl/rename_pkg.sv ====
`include "rename_config.svh"

package rename_pkg;

    // widest lane group, used to size lane counts and the popcount helper
    localparam int LANE_MAX = (`RENAME_WIDTH > `COMMIT_WIDTH) ? `RENAME_WIDTH : `COMMIT_WIDTH;

    typedef logic [`PRIDX_W-1:0] pr_idx_t;

    // lane 0 sits in the low bits
    typedef pr_idx_t [`RENAME_WIDTH-1:0] alloc_vec_t;
    typedef pr_idx_t [`COMMIT_WIDTH-1:0] dealloc_vec_t;

    // 0 to LANE_MAX lanes
    typedef logic [$clog2(LANE_MAX+1)-1:0] lane_cnt_t;

    // 0 to IPHYREG_NUM-1 free registers
    typedef logic [$clog2(`IPHYREG_NUM)-1:0] free_cnt_t;

    // number of set lanes in a mask
    function automatic lane_cnt_t count_ones(input logic [LANE_MAX-1:0] mask);
        lane_cnt_t cnt;
        cnt = '0;
        for (int i = 0; i < LANE_MAX; i++) begin
            cnt = cnt + lane_cnt_t'(mask[i]);
        end
        return cnt;
    endfunction

endpackage

// ==== include/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// allocation lanes per cycle from the rename stage
`define RENAME_WIDTH 4

// retire lanes: dealloc and commit share the same width
`define COMMIT_WIDTH 4

// integer physical register file size, p0 is never handed out
`define IPHYREG_NUM 64

// physical register index width
`define PRIDX_W 6

// free list pointer width
// 64 slots against at most 63 entries, so tail minus head never aliases
`define FL_PTR_W 6

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the free list testbench with Verilator and run it
# exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module freelist_tb -f vlog.f \
    --Mdir obj_dir -o freelist_sim > build.log 2>&1 \
    && ./obj_dir/freelist_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat "$LOG"
grep -q "TEST RESULT: PASS" "$LOG" && exit 0 || exit 1

// ==== verification/freelist_tb.sv ====
`timescale 1ns/1ns
`include "rename_config.svh"

module freelist_tb;

    localparam int RW   = `RENAME_WIDTH;
    localparam int CW   = `COMMIT_WIDTH;
    localparam int LW   = (RW > CW) ? RW : CW;
    localparam int HALF = 10;

    // cycle budgets per test, the run is cut off past their sum plus margin
    localparam int RANDOM_CYCLES  = 300;
    localparam int BUDGET_RESET   = 4;
    localparam int BUDGET_FULL    = 10;
    localparam int BUDGET_SPARSE  = 10;
    localparam int BUDGET_EXHAUST = 40;
    localparam int BUDGET_ORDER   = 15;
    localparam int BUDGET_RESTEER = 20;
    localparam int BUDGET_RANDOM  = RANDOM_CYCLES + 20;
    localparam int TIMEOUT_CYCLES = BUDGET_RESET + BUDGET_FULL + BUDGET_SPARSE + BUDGET_EXHAUST
                                    + BUDGET_ORDER + BUDGET_RESTEER + BUDGET_RANDOM + 100;

    logic                     clk;
    logic                     rst_n;
    logic [RW-1:0]            alloc_req;
    logic                     can_alloc;
    rename_pkg::alloc_vec_t   alloc_pr_idx;
    logic [CW-1:0]            dealloc_req;
    rename_pkg::dealloc_vec_t dealloc_pr_idx;
    logic [CW-1:0]            commit_vld;
    logic                     resteer_vld;

    // reference model
    // free_q runs from the committed head to the tail, the first spec_n are uncommitted
    rename_pkg::pr_idx_t free_q [$];
    rename_pkg::pr_idx_t in_use [$];
    int                  spec_n;

    logic  checking;
    logic  last_grant;
    string test_name;
    int    test_errs;
    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    cycle_cnt = 0;

    freelist UUT (
        .clk              ( clk            ),
        .i_rst_n          ( rst_n          ),
        .i_alloc_req      ( alloc_req      ),
        .o_can_alloc      ( can_alloc      ),
        .o_alloc_pr_idx   ( alloc_pr_idx   ),
        .i_dealloc_req    ( dealloc_req    ),
        .i_dealloc_pr_idx ( dealloc_pr_idx ),
        .i_commit_vld     ( commit_vld     ),
        .i_resteer_vld    ( resteer_vld    )
    );

    initial begin
        clk = 1'b0;
        forever #(HALF) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic int lanes_set(input logic [LW-1:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < LW; i++) begin
            if (mask[i]) n++;
        end
        return n;
    endfunction

    function automatic logic [LW-1:0] low_lanes(input int n);
        logic [LW-1:0] m;
        m = '0;
        for (int i = 0; i < LW; i++) begin
            if (i < n) m[i] = 1'b1;
        end
        return m;
    endfunction

    function automatic int free_count();
        return free_q.size() - spec_n;
    endfunction

    // expected grant, and the oldest free registers laid onto the set lanes
    function automatic logic expect_alloc(input logic [RW-1:0] mask, input logic flush,
                                          output rename_pkg::alloc_vec_t idx);
        int k;
        logic grant;
        idx = '0;
        k = 0;
        grant = !flush && (free_count() >= lanes_set(mask));
        for (int i = 0; i < RW; i++) begin
            if (mask[i]) begin
                if (spec_n + k < free_q.size()) idx[i] = free_q[spec_n + k];
                k++;
            end
        end
        return grant;
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        test_errs++;
        $display("error in %s: %s", test_name, msg);
    endtask

    task automatic check_grant(input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errs++;
            $display("Mismatch %s: o_can_alloc expected %0b actual %0b", test_name, exp, act);
        end
    endtask

    task automatic check_alloc(input rename_pkg::alloc_vec_t exp,
                               input rename_pkg::alloc_vec_t act,
                               input logic [RW-1:0] mask);
        checks++;
        for (int i = 0; i < RW; i++) begin
            if (mask[i] && (exp[i] !== act[i])) begin
                errors++;
                test_errs++;
                $display("Mismatch %s: lane %0d o_alloc_pr_idx expected %0d actual %0d",
                         test_name, i, exp[i], act[i]);
            end
        end
    endtask

    // the clock edge as the model sees it: grant, then commit, then flush, then dealloc
    task automatic advance_model(input logic grant);
        int ncommit;
        if (grant) spec_n += lanes_set(alloc_req);
        ncommit = lanes_set(commit_vld);
        if (ncommit > spec_n) begin
            report_failure("commit issued for more registers than are outstanding");
            ncommit = spec_n;
        end
        repeat (ncommit) in_use.push_back(free_q.pop_front());
        spec_n -= ncommit;
        if (resteer_vld) spec_n = 0;
        for (int i = 0; i < CW; i++) begin
            if (dealloc_req[i]) free_q.push_back(dealloc_pr_idx[i]);
        end
    endtask

    task automatic compare_cycle();
        rename_pkg::alloc_vec_t exp_idx;
        logic exp_grant;
        exp_grant = expect_alloc(alloc_req, resteer_vld, exp_idx);
        check_grant(exp_grant, can_alloc);
        if (exp_grant && (|alloc_req)) check_alloc(exp_idx, alloc_pr_idx, alloc_req);
        last_grant = can_alloc && (|alloc_req);
        advance_model(exp_grant);
    endtask

    // outputs have settled by 2 ns before the rising edge
    always @(negedge clk) begin
        #(HALF - 2);
        if (checking) compare_cycle();
    end

    task automatic drive_cycle(input logic [RW-1:0] req, input logic [CW-1:0] dreq,
                               input rename_pkg::dealloc_vec_t didx,
                               input logic [CW-1:0] cvld, input logic flush);
        @(negedge clk);
        alloc_req      = req;
        dealloc_req    = dreq;
        dealloc_pr_idx = didx;
        commit_vld     = cvld;
        resteer_vld    = flush;
        @(posedge clk);
    endtask

    // takes committed registers back on the wanted lanes, idle lanes carry junk
    task automatic pick_dealloc(input logic [CW-1:0] want, output logic [CW-1:0] dreq,
                                output rename_pkg::dealloc_vec_t didx);
        int j;
        dreq = '0;
        for (int i = 0; i < CW; i++) begin
            didx[i] = rename_pkg::pr_idx_t'($urandom);
            if (want[i] && in_use.size() > 0) begin
                j = $urandom_range(in_use.size() - 1);
                didx[i] = in_use[j];
                in_use.delete(j);
                dreq[i] = 1'b1;
            end
        end
    endtask

    task automatic commit_all();
        int n;
        while (spec_n > 0) begin
            n = (spec_n > CW) ? CW : spec_n;
            drive_cycle('0, '0, '0, low_lanes(n), 1'b0);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errs);
        end
    endtask

    task automatic test_full_alloc();
        start_test("full_alloc");
        repeat (4) drive_cycle('1, '0, '0, '1, 1'b0);
        end_test();
    endtask

    task automatic test_sparse_alloc();
        logic [RW-1:0] pattern [6];
        start_test("sparse_alloc");
        pattern = '{4'b1001, 4'b0110, 4'b0101, 4'b1010, 4'b0001, 4'b1000};
        for (int i = 0; i < 6; i++) begin
            drive_cycle(pattern[i], '0, '0, pattern[i], 1'b0);
        end
        end_test();
    endtask

    task automatic test_exhaustion();
        logic [CW-1:0] dreq;
        rename_pkg::dealloc_vec_t didx;
        int waited;
        start_test("exhaustion");
        while (free_count() >= RW) drive_cycle('1, '0, '0, '1, 1'b0);
        if (free_count() > 0) begin
            drive_cycle(low_lanes(free_count()), '0, '0, low_lanes(free_count()), 1'b0);
        end
        // empty list, the full mask stalls and is held
        repeat (2) drive_cycle('1, '0, '0, '0, 1'b0);
        pick_dealloc(4'b0101, dreq, didx);
        drive_cycle('1, dreq, didx, '0, 1'b0);
        // two free is still short of four lanes
        drive_cycle('1, '0, '0, '0, 1'b0);
        pick_dealloc(4'b1100, dreq, didx);
        drive_cycle('1, dreq, didx, '0, 1'b0);
        waited = 0;
        do begin
            drive_cycle('1, '0, '0, '0, 1'b0);
            waited++;
        end while (!last_grant && waited < 4);
        if (!last_grant) report_failure("no grant after four registers were returned");
        commit_all();
        end_test();
    endtask

    task automatic test_dealloc_order();
        logic [CW-1:0] dreq;
        rename_pkg::dealloc_vec_t didx;
        start_test("dealloc_order");
        pick_dealloc(4'b1010, dreq, didx);
        drive_cycle('0, dreq, didx, '0, 1'b0);
        pick_dealloc(4'b0101, dreq, didx);
        drive_cycle(4'b0001, dreq, didx, 4'b0001, 1'b0);
        drive_cycle(4'b1011, '0, '0, 4'b0111, 1'b0);
        pick_dealloc('1, dreq, didx);
        drive_cycle('0, dreq, didx, '0, 1'b0);
        drive_cycle('1, '0, '0, '1, 1'b0);
        end_test();
    endtask

    task automatic test_resteer();
        logic [CW-1:0] dreq;
        rename_pkg::dealloc_vec_t didx;
        start_test("resteer");
        repeat (3) begin
            pick_dealloc('1, dreq, didx);
            drive_cycle('0, dreq, didx, '0, 1'b0);
        end
        drive_cycle('1, '0, '0, '0, 1'b0);
        drive_cycle(4'b0110, '0, '0, '0, 1'b0);
        // flush with a request up and a register coming back
        pick_dealloc(4'b0010, dreq, didx);
        drive_cycle('1, dreq, didx, '0, 1'b1);
        drive_cycle('1, '0, '0, '0, 1'b0);
        drive_cycle(4'b0011, '0, '0, '0, 1'b0);
        commit_all();
        end_test();
    endtask

    task automatic test_random(input int num_cycles);
        logic [RW-1:0] req;
        logic [CW-1:0] dreq;
        logic [CW-1:0] cmask;
        rename_pkg::dealloc_vec_t didx;
        rename_pkg::alloc_vec_t scratch;
        logic flush;
        logic grant;
        logic held;
        int outstanding;
        int ncommit;
        int rot;
        start_test("random_mix");
        req = '0;
        held = 1'b0;
        for (int c = 0; c < num_cycles; c++) begin
            flush = ($urandom_range(15) == 0);
            // a stalled request stays up until granted or flushed
            if (!held) req = RW'($urandom);
            pick_dealloc(CW'($urandom), dreq, didx);
            grant = expect_alloc(req, flush, scratch);
            outstanding = spec_n + (grant ? lanes_set(req) : 0);
            ncommit = $urandom_range((outstanding > CW) ? CW : outstanding);
            rot = $urandom_range(CW - 1);
            cmask = low_lanes(ncommit);
            cmask = (cmask << rot) | (cmask >> (CW - rot));
            drive_cycle(req, dreq, didx, cmask, flush);
            held = (|req) && !grant && !flush;
        end
        commit_all();
        end_test();
    endtask

    initial begin
        void'($urandom(32'h5031));
        rst_n          = 1'b0;
        alloc_req      = '0;
        dealloc_req    = '0;
        dealloc_pr_idx = '0;
        commit_vld     = '0;
        resteer_vld    = 1'b0;
        checking       = 1'b0;
        last_grant     = 1'b0;
        test_name      = "reset";
        test_errs      = 0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        spec_n         = 0;
        // p0 stays out of the list
        for (int r = 1; r < `IPHYREG_NUM; r++) begin
            free_q.push_back(rename_pkg::pr_idx_t'(r));
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        checking = 1'b1;

        test_full_alloc();
        test_sparse_alloc();
        test_exhaustion();
        test_dealloc_order();
        test_resteer();
        test_random(RANDOM_CYCLES);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/rename_pkg.sv
hdl/freelist_if.sv
hdl/dealloc_compact.sv
hdl/alloc_scatter.sv
hdl/freelist_queue.sv
hdl/freelist_ctrl.sv
hdl/freelist.sv
verification/freelist_tb.sv
